// File: tb.f
+incdir+sim
logic/dcache_pkg.sv
logic/victim_lfsr.sv
logic/way_storage.sv
logic/line_writeback.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/tb_clkgen.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

// File: Makefile
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module dcache_top
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_pattern.svh
// Power-up memory contents, a scramble of the full word address
function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1_e995;
endfunction

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int RESET_CYCLES = 3;
    localparam int N_RANDOM = 300;
    localparam int N_OPS = 8 + 16 + 32 + 12 + N_RANDOM;
    localparam int CYCLES_PER_OP = 400;

    logic                     clk;
    logic                     rst;
    dcache_pkg::cpu_req_t     cpu_req;
    logic [31:0]              rdata;
    logic                     stall;
    dcache_pkg::mem_rd_req_t  mem_rd_req;
    dcache_pkg::mem_rd_resp_t mem_rd_resp;
    dcache_pkg::mem_wr_req_t  mem_wr_req;
    dcache_pkg::mem_wr_resp_t mem_wr_resp;
    int                       proto_errors;

    logic [31:0] shadow [int unsigned];
    int          reads_issued;
    int          reads_checked;
    int          last_latency;

    `include "tb_pattern.svh"

    tb_clkgen u_clkgen (
        .clk (clk)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .rd_req       (mem_rd_req),
        .rd_resp      (mem_rd_resp),
        .wr_req       (mem_wr_req),
        .wr_resp      (mem_wr_resp),
        .proto_errors (proto_errors)
    );

    dcache_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .rdata       (rdata),
        .stall       (stall),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_resp (mem_rd_resp),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_resp (mem_wr_resp)
    );

    // Last written value or the memory pattern if never written
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        int unsigned key;
        key = {2'b00, addr[31:2]};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return mem_pattern(addr);
    endfunction

    function automatic void record_write(input logic [31:0] addr, input logic [31:0] data,
                                         input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        shadow[{2'b00, addr[31:2]}] = (expected_word(addr) & ~mask) | (data & mask);
    endfunction

    task automatic halt_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // One CPU access that returns at the first falling edge with stall low
    task automatic cpu_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] be);
        while (stall) begin
            @(negedge clk);
        end
        cpu_req.read = !wr;
        cpu_req.write = wr;
        cpu_req.addr = addr;
        cpu_req.wdata = data;
        cpu_req.byteenable = be;
        if (wr) begin
            record_write(addr, data, be);
        end else begin
            reads_issued++;
        end
        @(negedge clk);
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;
        last_latency = 0;
        while (stall) begin
            @(negedge clk);
            last_latency++;
        end
    endtask

    // Catches each accepted read and checks the first unstalled rdata
    initial begin : compare
        logic [31:0] want;
        logic [31:0] addr;
        reads_checked = 0;
        forever begin
            @(posedge clk);
            if (!rst && !stall && cpu_req.read) begin
                addr = cpu_req.addr;
                want = expected_word(addr);
                @(negedge clk);
                while (stall) begin
                    @(negedge clk);
                end
                assert (rdata === want) else begin
                    $display("mismatch at %0t ns: rdata for address %h expected %h got %h",
                             $time, addr, want, rdata);
                    halt_with_failure();
                end
                reads_checked++;
            end
        end
    end

    // The memory model counts handshake faults on both ports
    always @(proto_errors) begin
        assert (proto_errors == 0) else begin
            $display("memory protocol error at %0t ns: %0d faults flagged by the memory model",
                     $time, proto_errors);
            halt_with_failure();
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + 32 + N_OPS * CYCLES_PER_OP) @(posedge clk);
        $display("watchdog expired: the run did not finish in %0d cycles",
                 RESET_CYCLES + 32 + N_OPS * CYCLES_PER_OP);
        halt_with_failure();
    end

    initial begin : stimulus
        logic [31:0] addr;
        void'($urandom(77693));
        rst = 1'b1;
        cpu_req = '0;
        reads_issued = 0;
        last_latency = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Untouched lines come straight from memory
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b0, 32'h0000_1000 + 32'(i * 36), '0, '0);
        end

        // Refill and then the same word again as a hit
        for (int i = 0; i < 8; i++) begin
            addr = 32'h0000_1800 + 32'(i * 68);
            cpu_access(1'b0, addr, '0, '0);
            cpu_access(1'b0, addr, '0, '0);
            assert (last_latency == 0) else begin
                $display("read hit at address %h stalled for %0d cycles after acceptance",
                         addr, last_latency);
                halt_with_failure();
            end
        end

        // Partial writes to cached lines and then to lines not yet cached
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b1, 32'h0000_1800 + 32'(i * 68), $urandom, 4'(i % 15 + 1));
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b1, 32'h0000_2400 + 32'(i * 44), $urandom, 4'(15 - i * 2));
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b0, 32'h0000_1800 + 32'(i * 68), '0, '0);
            cpu_access(1'b0, 32'h0000_2400 + 32'(i * 44), '0, '0);
        end

        // Six dirty lines in set 5 overflow its four ways
        for (int t = 0; t < 6; t++) begin
            cpu_access(1'b1, 32'h0000_30a0 + 32'(t * 512 + t * 4), $urandom, 4'hf);
        end
        for (int t = 0; t < 6; t++) begin
            cpu_access(1'b0, 32'h0000_30a0 + 32'(t * 512 + t * 4), '0, '0);
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            addr = 32'($urandom_range(63) * 32 + $urandom_range(7) * 4);
            if ($urandom_range(1) == 1) begin
                cpu_access(1'b1, addr, $urandom, 4'($urandom_range(15, 1)));
            end else begin
                cpu_access(1'b0, addr, '0, '0);
            end
        end

        repeat (4) @(negedge clk);
        if (reads_checked == reads_issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("end of run: only %0d of %0d reads were checked",
                     reads_checked, reads_issued);
            halt_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                     clk,
    input  dcache_pkg::mem_rd_req_t  rd_req,
    output dcache_pkg::mem_rd_resp_t rd_resp,
    input  dcache_pkg::mem_wr_req_t  wr_req,
    output dcache_pkg::mem_wr_resp_t wr_resp,
    output int                       proto_errors
);

    localparam int MEM_WORDS = 4096;

    logic [31:0] mem [MEM_WORDS];
    int          rd_errors;
    int          wr_errors;

    `include "tb_pattern.svh"

    // Backing store covers the low 16 KB
    function automatic int word_slot(input logic [31:0] addr);
        return int'(addr[13:2]);
    endfunction

    assign proto_errors = rd_errors + wr_errors;

    initial begin : read_port
        logic [31:0] base;
        rd_errors = 0;
        rd_resp = '0;
        forever begin
            @(negedge clk);
            if (rd_req.ar_valid) begin
                repeat ($urandom_range(3)) @(negedge clk);
                rd_resp.ar_ready = 1'b1;
                base = rd_req.ar_addr;
                if (base[4:0] != 5'd0) begin
                    rd_errors++;
                end
                @(negedge clk);
                rd_resp.ar_ready = 1'b0;
                for (int b = 0; b < 8; b++) begin
                    repeat ($urandom_range(3)) @(negedge clk);
                    if (!rd_req.r_ready) begin
                        rd_errors++;
                    end
                    rd_resp.r_valid = 1'b1;
                    rd_resp.r_data = mem[word_slot(base + 32'(b * 4))];
                    rd_resp.r_last = (b == 7);
                    @(negedge clk);
                    rd_resp.r_valid = 1'b0;
                    rd_resp.r_last = 1'b0;
                end
            end
        end
    end

    initial begin : write_port
        logic [31:0] base;
        wr_errors = 0;
        wr_resp = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = mem_pattern(32'(i * 4));
        end
        forever begin
            @(negedge clk);
            if (wr_req.aw_valid) begin
                repeat ($urandom_range(3)) @(negedge clk);
                wr_resp.aw_ready = 1'b1;
                base = wr_req.aw_addr;
                @(negedge clk);
                wr_resp.aw_ready = 1'b0;
                for (int b = 0; b < 8; b++) begin
                    repeat ($urandom_range(3)) @(negedge clk);
                    // Last flag must sit on the eighth beat only
                    if (!wr_req.w_valid || wr_req.w_last != (b == 7)) begin
                        wr_errors++;
                    end
                    mem[word_slot(base + 32'(b * 4))] = wr_req.w_data;
                    wr_resp.w_ready = 1'b1;
                    @(negedge clk);
                    wr_resp.w_ready = 1'b0;
                end
                repeat ($urandom_range(3)) @(negedge clk);
                if (!wr_req.b_ready) begin
                    wr_errors++;
                end
                wr_resp.b_valid = 1'b1;
                @(negedge clk);
                wr_resp.b_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);

    localparam int PERIOD_NS = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  dcache_pkg::cpu_req_t          cpu_req,
    output logic [dcache_pkg::WORD_W-1:0] rdata,
    output logic                          stall,
    output dcache_pkg::mem_rd_req_t       mem_rd_req,
    input  dcache_pkg::mem_rd_resp_t      mem_rd_resp,
    output dcache_pkg::mem_wr_req_t       mem_wr_req,
    input  dcache_pkg::mem_wr_resp_t      mem_wr_resp
);

    dcache_pkg::index_t                            ram_index;
    logic [dcache_pkg::WAYS-1:0]                   tag_we;
    logic [dcache_pkg::WAYS-1:0]                   data_we;
    dcache_pkg::tag_entry_t                        tag_wdata;
    dcache_pkg::line_t                             line_wdata;
    dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] tag_rdata;
    dcache_pkg::line_t [dcache_pkg::WAYS-1:0]      line_rdata;
    logic [dcache_pkg::WAY_W-1:0]                  victim_way;
    logic                                          lfsr_step;
    logic                                          wb_start;
    dcache_pkg::line_addr_t                        wb_line_addr;
    dcache_pkg::line_t                             wb_line;
    logic                                          wb_busy;
    dcache_pkg::line_addr_t                        wb_busy_addr;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .rdata        (rdata),
        .stall        (stall),
        .ram_index    (ram_index),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .tag_wdata    (tag_wdata),
        .line_wdata   (line_wdata),
        .tag_rdata    (tag_rdata),
        .line_rdata   (line_rdata),
        .victim_way   (victim_way),
        .lfsr_step    (lfsr_step),
        .wb_start     (wb_start),
        .wb_line_addr (wb_line_addr),
        .wb_line      (wb_line),
        .wb_busy      (wb_busy),
        .wb_busy_addr (wb_busy_addr),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_resp  (mem_rd_resp)
    );

    way_storage u_storage (
        .clk        (clk),
        .index      (ram_index),
        .tag_we     (tag_we),
        .data_we    (data_we),
        .tag_wdata  (tag_wdata),
        .line_wdata (line_wdata),
        .tag_rdata  (tag_rdata),
        .line_rdata (line_rdata)
    );

    victim_lfsr u_lfsr (
        .clk        (clk),
        .rst        (rst),
        .step       (lfsr_step),
        .victim_way (victim_way)
    );

    line_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .start       (wb_start),
        .line_addr   (wb_line_addr),
        .line        (wb_line),
        .busy        (wb_busy),
        .busy_addr   (wb_busy_addr),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_resp (mem_wr_resp)
    );

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  dcache_pkg::cpu_req_t                         cpu_req,
    output logic [dcache_pkg::WORD_W-1:0]                rdata,
    output logic                                         stall,
    output dcache_pkg::index_t                           ram_index,
    output logic [dcache_pkg::WAYS-1:0]                  tag_we,
    output logic [dcache_pkg::WAYS-1:0]                  data_we,
    output dcache_pkg::tag_entry_t                       tag_wdata,
    output dcache_pkg::line_t                            line_wdata,
    input  dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] tag_rdata,
    input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0]      line_rdata,
    input  logic [dcache_pkg::WAY_W-1:0]                 victim_way,
    output logic                                         lfsr_step,
    output logic                                         wb_start,
    output dcache_pkg::line_addr_t                       wb_line_addr,
    output dcache_pkg::line_t                            wb_line,
    input  logic                                         wb_busy,
    input  dcache_pkg::line_addr_t                       wb_busy_addr,
    output dcache_pkg::mem_rd_req_t                      mem_rd_req,
    input  dcache_pkg::mem_rd_resp_t                     mem_rd_resp
);

    localparam int LINE_OFF_W = dcache_pkg::OFFSET_W + dcache_pkg::BYTE_OFF_W;

    dcache_pkg::cache_state_t state, next_state;
    dcache_pkg::cpu_req_t     req;
    logic                     req_pending;
    logic                     accept;
    dcache_pkg::index_t       sweep_cnt;
    dcache_pkg::offset_t      beat_cnt;

    dcache_pkg::tag_bits_t  req_tag;
    dcache_pkg::index_t     req_index;
    dcache_pkg::offset_t    req_offset;
    dcache_pkg::line_addr_t req_line;
    dcache_pkg::index_t     cpu_index;

    logic [dcache_pkg::WAYS-1:0] hit_vec;
    logic                        hit;
    dcache_pkg::line_t           hit_line;
    dcache_pkg::line_t           recv_buf;
    dcache_pkg::line_t           fill_line;
    dcache_pkg::line_t           merged_line;
    dcache_pkg::tag_entry_t      victim_tag;
    logic                        victim_dirty;
    logic                        line_clash;

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req_offset = req.addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::OFFSET_W];
    assign req_index = req.addr[LINE_OFF_W +: dcache_pkg::INDEX_W];
    assign req_tag = req.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_line = {req_tag, req_index};
    assign cpu_index = cpu_req.addr[LINE_OFF_W +: dcache_pkg::INDEX_W];

    // Tag compare across all ways
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            hit_vec[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_tag);
            if (hit_vec[w]) begin
                hit_line = hit_line | line_rdata[w];
            end
        end
    end
    assign hit = |hit_vec;

    assign victim_tag = tag_rdata[victim_way];
    assign victim_dirty = victim_tag.valid && victim_tag.dirty;
    assign line_clash = wb_busy && (wb_busy_addr == req_line);

    assign wb_line_addr = {victim_tag.tag, req_index};
    assign wb_line = line_rdata[victim_way];

    // Refill line with the beat arriving this cycle patched in
    always_comb begin
        fill_line = recv_buf;
        fill_line[beat_cnt] = mem_rd_resp.r_data;
        merged_line = (state == dcache_pkg::RECV) ? fill_line : hit_line;
        if (req.write) begin
            merged_line[req_offset] = merge_bytes(merged_line[req_offset], req.wdata,
                                                  req.byteenable);
        end
    end
    assign line_wdata = merged_line;

    always_comb begin
        if (state == dcache_pkg::SWEEP) begin
            tag_wdata = '0;
        end else begin
            tag_wdata = '{valid: 1'b1, dirty: req.write, tag: req_tag};
        end
    end

    assign rdata = (state == dcache_pkg::DONE) ? recv_buf[req_offset] : hit_line[req_offset];

    always_comb begin
        next_state = state;
        stall = 1'b1;
        tag_we = '0;
        data_we = '0;
        lfsr_step = 1'b0;
        wb_start = 1'b0;
        mem_rd_req = '0;
        mem_rd_req.ar_addr = {req_line, {LINE_OFF_W{1'b0}}};
        unique case (state)
            dcache_pkg::SWEEP: begin
                tag_we = '1;
                if (sweep_cnt == '1) begin
                    next_state = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::IDLE: begin
                // Only a read hit lets the CPU move on right away
                stall = req_pending && !(req.read && hit);
                if (req_pending && hit && req.write) begin
                    tag_we = hit_vec;
                    data_we = hit_vec;
                    next_state = dcache_pkg::WRITE_HOLD;
                end else if (req_pending && !hit) begin
                    lfsr_step = 1'b1;
                    next_state = dcache_pkg::VICTIM;
                end
            end
            dcache_pkg::WRITE_HOLD: begin
                stall = 1'b0;
                next_state = dcache_pkg::IDLE;
            end
            dcache_pkg::VICTIM: begin
                if ((victim_dirty && wb_busy) || line_clash) begin
                    next_state = dcache_pkg::WAIT_WB;
                end else begin
                    wb_start = victim_dirty;
                    next_state = dcache_pkg::REQ_LINE;
                end
            end
            dcache_pkg::WAIT_WB: begin
                if (!wb_busy) begin
                    next_state = dcache_pkg::VICTIM;
                end
            end
            dcache_pkg::REQ_LINE: begin
                mem_rd_req.ar_valid = 1'b1;
                if (mem_rd_resp.ar_ready) begin
                    next_state = dcache_pkg::RECV;
                end
            end
            dcache_pkg::RECV: begin
                mem_rd_req.r_ready = 1'b1;
                if (mem_rd_resp.r_valid && mem_rd_resp.r_last) begin
                    tag_we[victim_way] = 1'b1;
                    data_we[victim_way] = 1'b1;
                    next_state = dcache_pkg::DONE;
                end
            end
            dcache_pkg::DONE: begin
                stall = 1'b0;
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    assign accept = !stall && (cpu_req.read || cpu_req.write);

    // Storage follows the incoming request whenever one may be taken
    always_comb begin
        if (state == dcache_pkg::SWEEP) begin
            ram_index = sweep_cnt;
        end else if (stall) begin
            ram_index = req_index;
        end else begin
            ram_index = cpu_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::SWEEP;
            sweep_cnt <= '0;
            req_pending <= 1'b0;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == dcache_pkg::SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            if (!stall) begin
                req_pending <= accept;
            end
            if (state == dcache_pkg::REQ_LINE) begin
                beat_cnt <= '0;
            end else if (state == dcache_pkg::RECV && mem_rd_resp.r_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= cpu_req;
        end
        if (state == dcache_pkg::RECV && mem_rd_resp.r_valid) begin
            recv_buf[beat_cnt] <= mem_rd_resp.r_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/line_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module line_writeback (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  dcache_pkg::line_addr_t    line_addr,
    input  dcache_pkg::line_t         line,
    output logic                      busy,
    output dcache_pkg::line_addr_t    busy_addr,
    output dcache_pkg::mem_wr_req_t   mem_wr_req,
    input  dcache_pkg::mem_wr_resp_t  mem_wr_resp
);

    localparam int LINE_OFF_W = dcache_pkg::OFFSET_W + dcache_pkg::BYTE_OFF_W;

    dcache_pkg::wb_state_t  state;
    dcache_pkg::line_addr_t addr_q;
    dcache_pkg::line_t      line_q;
    dcache_pkg::offset_t    beat;
    logic                   last_beat;

    assign last_beat = beat == dcache_pkg::offset_t'(dcache_pkg::WORDS_PER_LINE - 1);

    always_comb begin
        mem_wr_req = '0;
        mem_wr_req.aw_addr = {addr_q, {LINE_OFF_W{1'b0}}};
        mem_wr_req.w_data = line_q[beat];
        mem_wr_req.w_last = last_beat;
        mem_wr_req.b_ready = 1'b1;
        mem_wr_req.aw_valid = state == dcache_pkg::WB_ADDR;
        mem_wr_req.w_valid = state == dcache_pkg::WB_DATA;
    end

    assign busy = state != dcache_pkg::WB_IDLE;
    assign busy_addr = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::WB_IDLE;
            beat <= '0;
        end else begin
            unique case (state)
                dcache_pkg::WB_IDLE: begin
                    if (start) begin
                        state <= dcache_pkg::WB_ADDR;
                    end
                end
                dcache_pkg::WB_ADDR: begin
                    beat <= '0;
                    if (mem_wr_resp.aw_ready) begin
                        state <= dcache_pkg::WB_DATA;
                    end
                end
                dcache_pkg::WB_DATA: begin
                    if (mem_wr_resp.w_ready) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= dcache_pkg::WB_RESP;
                        end
                    end
                end
                dcache_pkg::WB_RESP: begin
                    if (mem_wr_resp.b_valid) begin
                        state <= dcache_pkg::WB_IDLE;
                    end
                end
            endcase
        end
    end

    // Own copy of the line, so the cache way can be refilled at once
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            addr_q <= line_addr;
            line_q <= line;
        end
    end

endmodule

`default_nettype wire

// File: logic/way_storage.sv
`timescale 1ns/1ps
`default_nettype none

module way_storage (
    input  logic                                         clk,
    input  dcache_pkg::index_t                           index,
    input  logic [dcache_pkg::WAYS-1:0]                  tag_we,
    input  logic [dcache_pkg::WAYS-1:0]                  data_we,
    input  dcache_pkg::tag_entry_t                       tag_wdata,
    input  dcache_pkg::line_t                            line_wdata,
    output dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] tag_rdata,
    output dcache_pkg::line_t [dcache_pkg::WAYS-1:0]      line_rdata
);

    dcache_pkg::tag_entry_t tag_mem [dcache_pkg::WAYS][dcache_pkg::SETS];
    dcache_pkg::line_t      line_mem [dcache_pkg::WAYS][dcache_pkg::SETS];

    // One shared index for read and write
    // A write in the same cycle returns the old contents
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][index] <= tag_wdata;
            end
            if (data_we[w]) begin
                line_mem[w][index] <= line_wdata;
            end
            tag_rdata[w] <= tag_mem[w][index];
            line_rdata[w] <= line_mem[w][index];
        end
    end

endmodule

`default_nettype wire

// File: logic/victim_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module victim_lfsr (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         step,
    output logic [dcache_pkg::WAY_W-1:0] victim_way
);

    logic [7:0] lfsr;
    logic       feedback;

    // Taps 8,6,5,4 give the full 255-state cycle
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'h5a;
        end else if (step) begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    assign victim_way = lfsr[dcache_pkg::WAY_W-1:0];

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Geometry
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WAYS = 4;
    localparam int WAY_W = 2;
    localparam int SETS = 16;
    localparam int INDEX_W = 4;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W = 3;
    localparam int BYTE_OFF_W = 2;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

    // Address fields
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [TAG_W-1:0] tag_bits_t;
    typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        tag_bits_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [3:0]        byteenable;
    } cpu_req_t;

    typedef struct packed {
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic              r_ready;
    } mem_rd_req_t;

    typedef struct packed {
        logic              ar_ready;
        logic              r_valid;
        logic [WORD_W-1:0] r_data;
        logic              r_last;
    } mem_rd_resp_t;

    typedef struct packed {
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic              w_valid;
        logic [WORD_W-1:0] w_data;
        logic              w_last;
        logic              b_ready;
    } mem_wr_req_t;

    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
    } mem_wr_resp_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        WRITE_HOLD,
        VICTIM,
        WAIT_WB,
        REQ_LINE,
        RECV,
        DONE
    } cache_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

endpackage

`default_nettype wire
